// ==== Bender.yml ====
package:
  name: ctrl_slave

sources:
  - common/ctrl_slave_pkg.sv
  - verilog/cfg_decode.sv
  - context/context_tracker.sv
  - context/job_regfile.sv
  - verilog/run_control.sv
  - verilog/ctrl_slave_top.sv
  - target: test
    files:
      - testbench/ctrl_slave_checker.sv
      - testbench/tb_ctrl_slave.sv

// ==== common/ctrl_slave_pkg.sv ====
/*
 * Control slave package
 * Register map, sizes and shared types of the engine control slave
 */

package ctrl_slave_pkg;

  // Sizes and counts
  localparam int unsigned DATA_WIDTH    = 32;
  localparam int unsigned ADDR_WIDTH    = 32;
  localparam int unsigned N_CORES       = 4;  // Also the id width, ids are one-hot
  localparam int unsigned N_CONTEXT     = 2;
  localparam int unsigned N_JOB_REGS    = 8;
  localparam int unsigned N_SW_EVT      = 8;
  localparam int unsigned REG_IDX_WIDTH = 4;

  localparam int unsigned SW_EVT_SEL_WIDTH  = $clog2(N_SW_EVT);
  localparam int unsigned CLEAR_CYCLES      = 3;
  localparam int unsigned CLEAR_CNT_WIDTH   = $clog2(CLEAR_CYCLES + 1);
  localparam int unsigned STATUS_PEND_LSB   = 8;  // Pending count position in STATUS

  // Shared types
  typedef logic [DATA_WIDTH-1:0]              data_t;
  typedef logic [N_CORES-1:0]                 core_id_t;
  typedef logic [$clog2(N_CONTEXT)-1:0]       ctx_idx_t;
  typedef logic [$clog2(N_CONTEXT+1)-1:0]     pending_t;
  typedef logic [REG_IDX_WIDTH-1:0]           reg_idx_t;
  typedef logic [$clog2(N_JOB_REGS)-1:0]      job_idx_t;
  typedef data_t [N_JOB_REGS-1:0]             job_regs_t;
  typedef logic [N_SW_EVT-1:0]                sw_evt_t;

  // Register indices (word addresses)
  localparam reg_idx_t REG_TRIGGER   = 4'd0;
  localparam reg_idx_t REG_ACQUIRE   = 4'd1;
  localparam reg_idx_t REG_STATUS    = 4'd2;
  localparam reg_idx_t REG_RUNNING   = 4'd3;
  localparam reg_idx_t REG_SOFTCLEAR = 4'd4;
  localparam reg_idx_t REG_SWEVT     = 4'd5;
  localparam reg_idx_t REG_JOB_BASE  = 4'd8;  // Job registers fill 8 to 15

  // Returned by ACQUIRE when no context can be claimed
  localparam data_t ACQUIRE_BUSY = '1;

endpackage

// ==== compile.f ====
common/ctrl_slave_pkg.sv
verilog/cfg_decode.sv
context/context_tracker.sv
context/job_regfile.sv
verilog/run_control.sv
verilog/ctrl_slave_top.sv
testbench/ctrl_slave_checker.sv
testbench/tb_ctrl_slave.sv

// ==== context/context_tracker.sv ====
/*
 * Job context tracker
 * Keeps the commit and run pointers, the pending count, the core that
 * offloaded each context and the critical section granted by ACQUIRE
 */

`timescale 1ns/1ps
`default_nettype none

module context_tracker (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      clear_i,
  input  logic                      acquire_i,
  input  logic                      commit_i,
  input  ctrl_slave_pkg::core_id_t  commit_core_i,
  input  logic                      done_accept_i,
  output ctrl_slave_pkg::ctx_idx_t  pointer_ctx_o,
  output ctrl_slave_pkg::ctx_idx_t  running_ctx_o,
  output ctrl_slave_pkg::pending_t  pending_o,
  output logic                      full_o,
  output logic                      job_pending_o,
  output logic                      acquire_ok_o,
  output ctrl_slave_pkg::core_id_t  run_core_o
);
  import ctrl_slave_pkg::*;

  typedef enum logic {CTX_IDLE, CTX_CRITICAL} ctx_state_e;

  ctx_state_e ctx_state_q;
  ctx_idx_t   pointer_q;
  ctx_idx_t   running_q;
  pending_t   pending_q;
  core_id_t   offload_core_q [N_CONTEXT];

  // Commit and run pointers, plus the number of queued jobs
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pointer_q <= '0;
      running_q <= '0;
      pending_q <= '0;
    end else if (clear_i) begin
      pointer_q <= '0;
      running_q <= '0;
      pending_q <= '0;
    end else begin
      if (commit_i)
        pointer_q <= (pointer_q == ctx_idx_t'(N_CONTEXT - 1)) ? '0 : pointer_q + 1'b1;
      if (done_accept_i)
        running_q <= (running_q == ctx_idx_t'(N_CONTEXT - 1)) ? '0 : running_q + 1'b1;
      if (commit_i && !done_accept_i)
        pending_q <= pending_q + 1'b1;
      else if (!commit_i && done_accept_i)
        pending_q <= pending_q - 1'b1;
    end
  end

  // Completion event target for each context
  always_ff @(posedge clk_i) begin
    if (commit_i) offload_core_q[pointer_q] <= commit_core_i;
  end

  // Critical section, held from a granted ACQUIRE until the commit
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ctx_state_q <= CTX_IDLE;
    end else if (clear_i) begin
      ctx_state_q <= CTX_IDLE;
    end else begin
      case (ctx_state_q)
        CTX_IDLE:     if (acquire_i && acquire_ok_o) ctx_state_q <= CTX_CRITICAL;
        CTX_CRITICAL: if (commit_i) ctx_state_q <= CTX_IDLE;
        default:      ctx_state_q <= CTX_IDLE;
      endcase
    end
  end

  assign full_o        = (pending_q == pending_t'(N_CONTEXT));
  assign job_pending_o = (running_q != pointer_q) || full_o;
  assign acquire_ok_o  = !full_o && (ctx_state_q == CTX_IDLE);
  assign pointer_ctx_o = pointer_q;
  assign running_ctx_o = running_q;
  assign pending_o     = pending_q;
  assign run_core_o    = offload_core_q[running_q];

endmodule

`default_nettype wire

// ==== context/job_regfile.sv ====
/*
 * Contexted job register file
 * Stores the job registers per context and builds the registered
 * peripheral read data
 */

`timescale 1ns/1ps
`default_nettype none

module job_regfile (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       clear_i,
  input  logic                       job_we_i,
  input  ctrl_slave_pkg::job_idx_t   job_idx_i,
  input  ctrl_slave_pkg::data_t      wdata_i,
  input  ctrl_slave_pkg::ctx_idx_t   pointer_ctx_i,
  input  ctrl_slave_pkg::ctx_idx_t   running_ctx_i,
  input  ctrl_slave_pkg::pending_t   pending_i,
  input  logic                       acquire_ok_i,
  input  logic                       is_working_i,
  input  ctrl_slave_pkg::reg_idx_t   rd_sel_i,
  output ctrl_slave_pkg::data_t      cfg_r_data_o,
  output ctrl_slave_pkg::job_regs_t  job_regs_o
);
  import ctrl_slave_pkg::*;

  job_regs_t regs_q [N_CONTEXT];
  data_t     rd_data;

  // Writes always land in the context being programmed
  always_ff @(posedge clk_i) begin
    if (clear_i) begin
      for (int c = 0; c < N_CONTEXT; c++) regs_q[c] <= '0;
    end else if (job_we_i) begin
      regs_q[pointer_ctx_i][job_idx_i] <= wdata_i;
    end
  end

  assign job_regs_o = regs_q[running_ctx_i];  // Engine sees the running job

  always_comb begin
    rd_data = '0;
    if (rd_sel_i >= REG_JOB_BASE) begin
      rd_data = regs_q[pointer_ctx_i][job_idx_t'(rd_sel_i - REG_JOB_BASE)];
    end else begin
      case (rd_sel_i)
        REG_STATUS: begin
          rd_data[0] = is_working_i;
          rd_data[STATUS_PEND_LSB +: $bits(pending_t)] = pending_i;
        end
        REG_RUNNING: rd_data = data_t'(running_ctx_i);
        REG_ACQUIRE: rd_data = acquire_ok_i ? data_t'(pointer_ctx_i) : ACQUIRE_BUSY;
        default:     rd_data = '0;
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) cfg_r_data_o <= '0;
    else         cfg_r_data_o <= rd_data;
  end

endmodule

`default_nettype wire

// ==== testbench/ctrl_slave_checker.sv ====
/*
 * Control slave checker
 * Cycle model of the offload protocol, compares every DUT output
 */

`timescale 1ns/1ps
`default_nettype none

module ctrl_slave_checker (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      req_i,
  input  logic                      wen_i,
  input  ctrl_slave_pkg::data_t     add_i,
  input  ctrl_slave_pkg::data_t     wdata_i,
  input  ctrl_slave_pkg::core_id_t  id_i,
  input  logic                      done_i,
  input  logic                      gnt_i,
  input  ctrl_slave_pkg::data_t     r_data_i,
  input  logic                      r_valid_i,
  input  ctrl_slave_pkg::core_id_t  r_id_i,
  input  logic                      start_i,
  input  logic                      is_working_i,
  input  ctrl_slave_pkg::job_regs_t job_regs_i,
  input  ctrl_slave_pkg::core_id_t  evt_i,
  input  ctrl_slave_pkg::sw_evt_t   sw_evt_i,
  input  logic                      clear_i
);
  import ctrl_slave_pkg::*;

  data_t    m_regs [N_CONTEXT][N_JOB_REGS];
  core_id_t m_core [N_CONTEXT];
  int       m_ptr, m_run, m_pend, m_clr_cnt;
  bit       m_crit, m_trig, m_work, m_startp, m_start, m_gap, m_valid, m_rd, m_clear;
  core_id_t m_rid, m_evt;
  sw_evt_t  m_sw;
  data_t    m_rdata;
  job_regs_t m_jobs;
  int       error_count = 0;
  int       test_errors = 0;
  int       test_count = 0;

  // Value a read returns, taken from the state before the edge
  function automatic data_t read_value(reg_idx_t idx);
    if (idx >= REG_JOB_BASE) return m_regs[m_ptr][idx - REG_JOB_BASE];
    case (idx)
      REG_STATUS:  return data_t'((m_pend << 8) | m_work);
      REG_RUNNING: return data_t'(m_run);
      REG_ACQUIRE: return (m_pend != N_CONTEXT && !m_crit) ? data_t'(m_ptr) : '1;
      default:     return '0;
    endcase
  endfunction

  task automatic clear_state();
    m_ptr = 0; m_run = 0; m_pend = 0;
    m_crit = 0; m_trig = 0; m_work = 0; m_startp = 0; m_start = 0; m_gap = 0;
    m_evt = '0;
    foreach (m_regs[c, r]) m_regs[c][r] = '0;
  endtask

  task automatic step();
    reg_idx_t idx;
    bit       rd, wr, commit, dacc, launch;
    data_t    rv;
    idx    = add_i[REG_IDX_WIDTH+1:2];
    rd     = req_i && wen_i;
    wr     = req_i && !wen_i;
    commit = wr && idx == REG_TRIGGER;
    rv     = read_value(idx);
    dacc   = done_i && m_work;
    launch = !m_work && m_pend != 0 && m_trig && !m_gap;
    m_valid = req_i;
    m_rd    = rd;
    if (req_i) m_rid = id_i;
    if (rd) m_rdata = rv;
    m_sw = '0;
    if (wr && idx == REG_SWEVT && !m_clear) m_sw[wdata_i % N_SW_EVT] = 1'b1;
    if (m_clear) begin
      clear_state();
    end else begin
      m_start  = m_startp && !dacc;
      m_startp = launch;
      if (launch) m_work = 1;
      else if (dacc) m_work = 0;
      if (commit && wdata_i == '0) m_trig = 1;
      else if (launch) m_trig = 0;
      m_gap = dacc;
      m_evt = dacc ? m_core[m_run] : '0;
      if (!m_crit) m_crit = rd && idx == REG_ACQUIRE && m_pend != N_CONTEXT;
      else if (commit) m_crit = 0;
      if (wr && idx >= REG_JOB_BASE) m_regs[m_ptr][idx - REG_JOB_BASE] = wdata_i;
      m_pend = m_pend + int'(commit) - int'(dacc);
      if (dacc) m_run = (m_run + 1) % N_CONTEXT;
    end
    if (commit) m_core[m_ptr] = id_i;  // Offload core is not cleared
    if (commit && !m_clear) m_ptr = (m_ptr + 1) % N_CONTEXT;
    m_clear = (m_clr_cnt != 0);
    if (m_clr_cnt == 0) m_clr_cnt = (wr && idx == REG_SOFTCLEAR) ? 1 : 0;
    else m_clr_cnt = (m_clr_cnt == CLEAR_CYCLES) ? 0 : m_clr_cnt + 1;
  endtask

  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      clear_state();
      m_valid = 0; m_rd = 0; m_rid = '0; m_sw = '0; m_clear = 0; m_clr_cnt = 0;
      foreach (m_core[c]) m_core[c] = '0;
    end else begin
      step();
    end
  end

  task automatic check(string name, logic [255:0] exp, logic [255:0] got);
    if (got !== exp) begin
      error_count++;
      test_errors++;
      $display("error: %s expected %h got %h at %0t", name, exp, got, $time);
    end
  endtask

  // Outputs are registered, so the falling edge sees them settled
  always @(negedge clk_i) begin
    if (rst_ni) begin
      check("cfg_gnt_o", 1'b1, gnt_i);
      check("cfg_r_valid_o", m_valid, r_valid_i);
      check("cfg_r_id_o", m_rid, r_id_i);
      if (m_valid && m_rd) check("cfg_r_data_o", m_rdata, r_data_i);
      check("start_o", m_start, start_i);
      check("is_working_o", m_work, is_working_i);
      check("evt_o", m_evt, evt_i);
      check("sw_evt_o", m_sw, sw_evt_i);
      check("clear_o", m_clear, clear_i);
      foreach (m_jobs[r]) m_jobs[r] = m_regs[m_run][r];
      if (m_work) check("job_regs_o", m_jobs, job_regs_i);
    end
  end

  task automatic end_test(string name);
    test_count++;
    if (test_errors == 0) $display("test %0d %s: ok", test_count, name);
    else $display("test %0d %s: %0d errors", test_count, name, test_errors);
    test_errors = 0;
  endtask

endmodule

`default_nettype wire

// ==== testbench/tb_ctrl_slave.sv ====
/*
 * Control slave testbench
 * Random offload traffic against the checker model, with a fake engine
 */

`timescale 1ns/1ps
`default_nettype none

module tb_ctrl_slave;
  import ctrl_slave_pkg::*;

  localparam int RESET_CYCLES = 16;
  localparam int MAX_CYCLES = RESET_CYCLES + 20 + 40 + 60 + 200 + 40 + 100 + 200;

  logic      clk_i = 1'b0;
  logic      rst_ni;
  logic      cfg_req_i, cfg_wen_i, done_i;
  data_t     cfg_add_i, cfg_data_i, cfg_r_data_o;
  core_id_t  cfg_id_i, cfg_r_id_o, evt_o;
  logic      cfg_gnt_o, cfg_r_valid_o, start_o, is_working_o, clear_o;
  job_regs_t job_regs_o;
  sw_evt_t   sw_evt_o;
  int        cycles = 0;

  always #5 clk_i = ~clk_i;

  ctrl_slave_top UUT (.*);

  ctrl_slave_checker CHK (
    .clk_i, .rst_ni, .req_i (cfg_req_i), .wen_i (cfg_wen_i), .add_i (cfg_add_i),
    .wdata_i (cfg_data_i), .id_i (cfg_id_i), .done_i, .gnt_i (cfg_gnt_o),
    .r_data_i (cfg_r_data_o), .r_valid_i (cfg_r_valid_o), .r_id_i (cfg_r_id_o),
    .start_i (start_o), .is_working_i (is_working_o), .job_regs_i (job_regs_o),
    .evt_i (evt_o), .sw_evt_i (sw_evt_o), .clear_i (clear_o)
  );

  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  // Engine answers each start with done 5 to 40 cycles later
  always begin
    @(negedge clk_i);
    if (rst_ni && start_o) begin
      repeat (5 + $urandom % 36) @(negedge clk_i);
      done_i = 1'b1;
      @(negedge clk_i);
      done_i = 1'b0;
    end
  end

  function automatic core_id_t rand_core();
    return core_id_t'(1 << ($urandom % N_CORES));
  endfunction

  task automatic drive_idle();
    cfg_req_i  = 1'b0;
    cfg_wen_i  = 1'b0;
    cfg_add_i  = '0;
    cfg_data_i = '0;
    cfg_id_i   = '0;
  endtask

  task automatic bus_access(bit rd, reg_idx_t idx, data_t d, core_id_t id);
    cfg_req_i  = 1'b1;
    cfg_wen_i  = rd;
    cfg_add_i  = data_t'({idx, 2'b00});
    cfg_data_i = d;
    cfg_id_i   = id;
    @(negedge clk_i);
    drive_idle();
  endtask

  task automatic offload_job(core_id_t id, int nregs, bit trig);
    bus_access(1, REG_ACQUIRE, '0, id);
    for (int i = 0; i < nregs; i++) bus_access(0, reg_idx_t'(REG_JOB_BASE + i), $urandom, id);
    bus_access(0, REG_TRIGGER, trig ? '0 : data_t'(1), id);
  endtask

  task automatic wait_evt();
    while (evt_o == '0) @(negedge clk_i);
    @(negedge clk_i);
  endtask

  initial begin
    bit       trig_a;
    core_id_t core_a;
    void'($urandom(32'h9411_3f95));
    drive_idle();
    done_i = 1'b0;
    rst_ni = 1'b0;
    repeat (RESET_CYCLES) @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);
    bus_access(0, REG_SOFTCLEAR, '0, 4'b0001);  // Zero the job registers
    repeat (6) @(negedge clk_i);

    bus_access(1, REG_ACQUIRE, '0, 4'b0001);
    for (int i = 0; i < N_JOB_REGS; i++) begin
      bus_access(0, reg_idx_t'(REG_JOB_BASE + i), $urandom, 4'b0001);
    end
    for (int i = 0; i < N_JOB_REGS; i++) begin
      bus_access(1, reg_idx_t'(REG_JOB_BASE + i), '0, rand_core());
    end
    CHK.end_test("register access");

    bus_access(0, REG_TRIGGER, '0, 4'b0001);
    wait_evt();
    while (is_working_o) @(negedge clk_i);
    CHK.end_test("single offload");

    trig_a = ($urandom % 2) != 0;
    core_a = rand_core();
    offload_job(core_a, N_JOB_REGS, trig_a);
    offload_job({core_a[N_CORES-2:0], core_a[N_CORES-1]}, 2, 1'b1);  // Another core
    bus_access(1, REG_ACQUIRE, '0, rand_core());
    bus_access(1, REG_STATUS, '0, rand_core());
    bus_access(1, REG_RUNNING, '0, rand_core());
    wait_evt();
    bus_access(1, REG_STATUS, '0, rand_core());
    bus_access(1, REG_RUNNING, '0, rand_core());
    if (!trig_a) offload_job(rand_core(), 1, 1'b1);  // Second trigger starts the queued job
    wait_evt();
    while (is_working_o) @(negedge clk_i);
    bus_access(1, REG_STATUS, '0, rand_core());
    CHK.end_test("queueing");

    repeat (8) begin
      bus_access(0, REG_SWEVT, $urandom, rand_core());
      repeat ($urandom % 3) @(negedge clk_i);
    end
    CHK.end_test("software events");

    offload_job(rand_core(), N_JOB_REGS, 1'b1);
    while (!is_working_o) @(negedge clk_i);
    repeat (3) @(negedge clk_i);
    bus_access(0, REG_SOFTCLEAR, '0, rand_core());
    repeat (6) @(negedge clk_i);
    bus_access(1, REG_STATUS, '0, rand_core());
    for (int i = 0; i < N_JOB_REGS; i++) begin
      bus_access(1, reg_idx_t'(REG_JOB_BASE + i), '0, rand_core());
    end
    bus_access(1, REG_ACQUIRE, '0, rand_core());
    repeat (2) @(negedge clk_i);
    CHK.end_test("soft clear");

    $display("summary: %0d tests, %0d errors", CHK.test_count, CHK.error_count);
    if (CHK.error_count == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog/cfg_decode.sv ====
/*
 * Peripheral request decoder
 * Turns requests into operation strobes, registers the read response
 * handshake and generates software events and the soft clear pulse
 */

`timescale 1ns/1ps
`default_nettype none

module cfg_decode (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      cfg_req_i,
  input  logic                      cfg_wen_i,      // High for a read
  input  ctrl_slave_pkg::data_t     cfg_add_i,
  input  ctrl_slave_pkg::data_t     cfg_data_i,
  input  ctrl_slave_pkg::core_id_t  cfg_id_i,
  output logic                      cfg_gnt_o,
  output logic                      cfg_r_valid_o,
  output ctrl_slave_pkg::core_id_t  cfg_r_id_o,
  output logic                      acquire_o,
  output logic                      commit_o,
  output logic                      trigger_o,
  output logic                      job_we_o,
  output ctrl_slave_pkg::job_idx_t  job_idx_o,
  output ctrl_slave_pkg::data_t     wdata_o,
  output ctrl_slave_pkg::core_id_t  commit_core_o,
  output ctrl_slave_pkg::reg_idx_t  rd_sel_o,
  output ctrl_slave_pkg::sw_evt_t   sw_evt_o,
  output logic                      clear_o
);
  import ctrl_slave_pkg::*;

  reg_idx_t                   reg_idx;
  logic                       is_rd;
  logic                       is_wr;
  logic                       swevt_wr;
  logic                       clear_wr;
  logic [CLEAR_CNT_WIDTH-1:0] clear_cnt_q;

  assign reg_idx   = cfg_add_i[REG_IDX_WIDTH+1:2];  // Drop byte offset
  assign is_rd     = cfg_req_i & cfg_wen_i;
  assign is_wr     = cfg_req_i & ~cfg_wen_i;

  // Operation strobes
  assign acquire_o     = is_rd && (reg_idx == REG_ACQUIRE);
  assign commit_o      = is_wr && (reg_idx == REG_TRIGGER);
  assign trigger_o     = commit_o && (cfg_data_i == '0);  // Zero data also triggers
  assign job_we_o      = is_wr && (reg_idx >= REG_JOB_BASE);
  assign job_idx_o     = job_idx_t'(reg_idx - REG_JOB_BASE);
  assign wdata_o       = cfg_data_i;
  assign commit_core_o = cfg_id_i;
  assign rd_sel_o      = reg_idx;
  assign swevt_wr      = is_wr && (reg_idx == REG_SWEVT);
  assign clear_wr      = is_wr && (reg_idx == REG_SOFTCLEAR);

  assign cfg_gnt_o = 1'b1;  // Never back-pressured

  // Response handshake, one cycle after the request
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cfg_r_valid_o <= 1'b0;
      cfg_r_id_o    <= '0;
    end else begin
      cfg_r_valid_o <= cfg_req_i;
      if (cfg_req_i) cfg_r_id_o <= cfg_id_i;
    end
  end

  // One-cycle software event on bit (data mod N_SW_EVT)
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sw_evt_o <= '0;
    end else begin
      sw_evt_o <= '0;
      if (swevt_wr && !clear_o) sw_evt_o[cfg_data_i[SW_EVT_SEL_WIDTH-1:0]] <= 1'b1;
    end
  end

  // Soft clear counter, the pulse lags the counter by one cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      clear_cnt_q <= '0;
      clear_o     <= 1'b0;
    end else begin
      if (clear_cnt_q == '0) begin
        if (clear_wr) clear_cnt_q <= CLEAR_CNT_WIDTH'(1);
      end else if (clear_cnt_q == CLEAR_CNT_WIDTH'(CLEAR_CYCLES)) begin
        clear_cnt_q <= '0;
      end else begin
        clear_cnt_q <= clear_cnt_q + 1'b1;
      end
      clear_o <= (clear_cnt_q != '0);
    end
  end

endmodule

`default_nettype wire

// ==== verilog/ctrl_slave_top.sv ====
/*
 * Engine control slave top level
 * Chains request decode, context tracking, job registers and run control
 */

`timescale 1ns/1ps
`default_nettype none

module ctrl_slave_top (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       cfg_req_i,
  input  logic                       cfg_wen_i,
  input  ctrl_slave_pkg::data_t      cfg_add_i,
  input  ctrl_slave_pkg::data_t      cfg_data_i,
  input  ctrl_slave_pkg::core_id_t   cfg_id_i,
  output logic                       cfg_gnt_o,
  output ctrl_slave_pkg::data_t      cfg_r_data_o,
  output logic                       cfg_r_valid_o,
  output ctrl_slave_pkg::core_id_t   cfg_r_id_o,
  input  logic                       done_i,
  output logic                       start_o,
  output logic                       is_working_o,
  output ctrl_slave_pkg::job_regs_t  job_regs_o,
  output ctrl_slave_pkg::core_id_t   evt_o,
  output ctrl_slave_pkg::sw_evt_t    sw_evt_o,
  output logic                       clear_o
);
  import ctrl_slave_pkg::*;

  logic     acquire, commit, trigger, job_we;
  job_idx_t job_idx;
  data_t    wdata;
  core_id_t commit_core;
  reg_idx_t rd_sel;
  ctx_idx_t pointer_ctx, running_ctx;
  pending_t pending;
  logic     job_pending, acquire_ok, done_accept;
  core_id_t run_core;

  cfg_decode i_cfg_decode (
    .clk_i, .rst_ni, .cfg_req_i, .cfg_wen_i, .cfg_add_i, .cfg_data_i, .cfg_id_i,
    .cfg_gnt_o, .cfg_r_valid_o, .cfg_r_id_o,
    .acquire_o (acquire), .commit_o (commit), .trigger_o (trigger),
    .job_we_o (job_we), .job_idx_o (job_idx), .wdata_o (wdata),
    .commit_core_o (commit_core), .rd_sel_o (rd_sel), .sw_evt_o, .clear_o
  );

  context_tracker i_context_tracker (
    .clk_i, .rst_ni, .clear_i (clear_o), .acquire_i (acquire), .commit_i (commit),
    .commit_core_i (commit_core), .done_accept_i (done_accept),
    .pointer_ctx_o (pointer_ctx), .running_ctx_o (running_ctx), .pending_o (pending),
    .full_o (), .job_pending_o (job_pending), .acquire_ok_o (acquire_ok),
    .run_core_o (run_core)
  );

  job_regfile i_job_regfile (
    .clk_i, .rst_ni, .clear_i (clear_o), .job_we_i (job_we), .job_idx_i (job_idx),
    .wdata_i (wdata), .pointer_ctx_i (pointer_ctx), .running_ctx_i (running_ctx),
    .pending_i (pending), .acquire_ok_i (acquire_ok), .is_working_i (is_working_o),
    .rd_sel_i (rd_sel), .cfg_r_data_o, .job_regs_o
  );

  run_control i_run_control (
    .clk_i, .rst_ni, .clear_i (clear_o), .trigger_i (trigger),
    .job_pending_i (job_pending), .run_core_i (run_core), .done_i,
    .start_o, .is_working_o, .done_accept_o (done_accept), .evt_o
  );

endmodule

`default_nettype wire

// ==== verilog/run_control.sv ====
/*
 * Run controller
 * Starts queued jobs on the engine, accepts done and raises the
 * completion event towards the core that offloaded the job
 */

`timescale 1ns/1ps
`default_nettype none

module run_control (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      clear_i,
  input  logic                      trigger_i,
  input  logic                      job_pending_i,
  input  ctrl_slave_pkg::core_id_t  run_core_i,
  input  logic                      done_i,
  output logic                      start_o,
  output logic                      is_working_o,
  output logic                      done_accept_o,
  output ctrl_slave_pkg::core_id_t  evt_o
);

  typedef enum logic [1:0] {RUN_IDLE, RUN_STARTING, RUN_BUSY} run_state_e;

  run_state_e run_state_q;
  logic       trig_q;     // Trigger waiting for a job to launch
  logic       gap_q;      // Keeps idle one extra cycle after done
  logic       launch;

  assign done_accept_o = done_i & is_working_o;  // Ignore stray done
  assign launch = (run_state_q == RUN_IDLE) && job_pending_i && trig_q && !gap_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      trig_q <= 1'b0;
      gap_q  <= 1'b0;
    end else if (clear_i) begin
      trig_q <= 1'b0;
      gap_q  <= 1'b0;
    end else begin
      if (trigger_i)   trig_q <= 1'b1;  // New trigger wins over consumption
      else if (launch) trig_q <= 1'b0;
      gap_q <= done_accept_o;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      run_state_q  <= RUN_IDLE;
      is_working_o <= 1'b0;
      start_o      <= 1'b0;
    end else if (clear_i) begin
      run_state_q  <= RUN_IDLE;
      is_working_o <= 1'b0;
      start_o      <= 1'b0;
    end else begin
      start_o <= 1'b0;
      case (run_state_q)
        RUN_IDLE: begin
          if (launch) begin
            run_state_q  <= RUN_STARTING;
            is_working_o <= 1'b1;
          end
        end
        RUN_STARTING, RUN_BUSY: begin
          if (done_accept_o) begin
            run_state_q  <= RUN_IDLE;
            is_working_o <= 1'b0;
          end else if (run_state_q == RUN_STARTING) begin
            run_state_q <= RUN_BUSY;
            start_o     <= 1'b1;   // Single pulse one cycle after working rises
          end
        end
        default: begin
          run_state_q  <= RUN_IDLE;
          is_working_o <= 1'b0;
        end
      endcase
    end
  end

  // Completion event to the core owning the running context
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni)       evt_o <= '0;
    else if (clear_i)  evt_o <= '0;
    else               evt_o <= done_accept_o ? run_core_i : '0;
  end

endmodule

`default_nettype wire
